//--- Makefile
VERILATOR ?= verilator
TOP       := tb_noc_tile
FILELIST  := compile.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)
RUN_FLAGS := +verilator+error+limit+1000
LOG       := sim.log
PASS_MSG  := SIMULATION PASSED

.PHONY: all compile run clean

all: run

# build the simulation executable
compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# run and check the log for the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
+incdir+verilog
verilog/tile_pkg.sv
verilog/tile_reset_ctrl.sv
verilog/irq_sync.sv
verilog/noc_req_packer.sv
verilog/noc_resp_unpacker.sv
verilog/noc_tile_top.sv
test/noc_tile_props.sv
test/tb_noc_tile.sv

//--- test/noc_tile_props.sv
`timescale 1ns/10ps
`include "tile_settings.svh"

module noc_tile_props
  import tile_pkg::*;
(
  input logic                       clk_i,
  input logic                       reset_l,
  input logic                       spc_grst_l,
  input logic [`TILE_IRQ_WIDTH-1:0] irq_i,
  input logic                       ipi_i,
  input logic                       time_irq_i,
  input logic                       debug_req_i,
  input logic [`TILE_IRQ_WIDTH-1:0] irq_o,
  input logic                       ipi_o,
  input logic                       time_irq_o,
  input logic                       debug_req_o,
  input logic                       psel_i,
  input logic                       penable_i,
  input logic                       pready_o,
  input logic                       pslverr_o,
  input logic                       noc2_valid_o,
  input noc_flit_t                  noc2_data_o,
  input logic                       noc2_ready_i,
  input logic                       noc3_ready_o
);

  int unsigned fail_cnt;

  logic [`TILE_IRQ_WIDTH+2:0] lines_in;
  logic [`TILE_IRQ_WIDTH+2:0] lines_out;

  initial fail_cnt = 0;

  assign lines_in  = {irq_i, ipi_i, time_irq_i, debug_req_i};
  assign lines_out = {irq_o, ipi_o, time_irq_o, debug_req_o};

  //////////////////////////////////////////////////
  // reset and interrupt lines
  //////////////////////////////////////////////////

  // release 34 cycles after reset_l rises
  wake_release: assert property (@(posedge clk_i)
    $rose(spc_grst_l) |-> $past(reset_l, 34) && !$past(reset_l, 35))
    else begin
      fail_cnt++;
      $error("tile reset released at the wrong cycle");
    end

  quiet_in_reset: assert property (@(posedge clk_i)
    !spc_grst_l |-> !noc2_valid_o && !pready_o && !pslverr_o && !noc3_ready_o)
    else begin
      fail_cnt++;
      $error("bridge output active during tile reset");
    end

  // two flop delay once both stages are out of reset
  line_delay: assert property (@(posedge clk_i)
    $past(spc_grst_l, 2) |-> lines_out == $past(lines_in, 2))
    else begin
      fail_cnt++;
      $error("synchronized line does not follow its input two cycles later");
    end

  //////////////////////////////////////////////////
  // noc2 and apb handshakes
  //////////////////////////////////////////////////

  flit_hold: assert property (@(posedge clk_i) disable iff (!spc_grst_l)
    noc2_valid_o && !noc2_ready_i |=> noc2_valid_o && $stable(noc2_data_o))
    else begin
      fail_cnt++;
      $error("noc2 flit changed or dropped under backpressure");
    end

  // header follows the first access cycle
  first_flit: assert property (@(posedge clk_i) disable iff (!spc_grst_l)
    $rose(noc2_valid_o) |-> $past(psel_i && penable_i) && !$past(penable_i, 2))
    else begin
      fail_cnt++;
      $error("noc2 packet did not start right after the first apb access cycle");
    end

  valid_in_access: assert property (@(posedge clk_i) disable iff (!spc_grst_l)
    noc2_valid_o || pready_o |-> psel_i && penable_i)
    else begin
      fail_cnt++;
      $error("noc2 valid or pready outside an apb access");
    end

  ready_pulse: assert property (@(posedge clk_i) disable iff (!spc_grst_l)
    pready_o |=> !pready_o)
    else begin
      fail_cnt++;
      $error("pready held longer than one cycle");
    end

endmodule

//--- test/tb_noc_tile.sv
`timescale 1ns/10ps
`include "tile_settings.svh"

module tb_noc_tile
  import tile_pkg::*;
();

  localparam int reset_cycles    = 10;
  localparam int wake_cycles     = 34;
  localparam int num_xfers       = 24;
  // worst case per transfer with backpressure on noc2, room for 40 of them
  localparam int xfer_budget     = 40;
  localparam int cycles_per_xfer = 48;
  localparam int max_cycles      = reset_cycles + wake_cycles + xfer_budget * cycles_per_xfer;

  logic                       clk_i;
  logic                       reset_l;
  logic                       spc_grst_l;
  chipid_t                    src_chipid_i;
  coord_t                     src_x_i;
  coord_t                     src_y_i;
  logic [`TILE_IRQ_WIDTH-1:0] irq_i;
  logic                       ipi_i;
  logic                       time_irq_i;
  logic                       debug_req_i;
  logic [`TILE_IRQ_WIDTH-1:0] irq_o;
  logic                       ipi_o;
  logic                       time_irq_o;
  logic                       debug_req_o;
  logic                       psel_i;
  logic                       penable_i;
  logic                       pwrite_i;
  apb_addr_t                  paddr_i;
  apb_data_t                  pwdata_i;
  apb_strb_t                  pstrb_i;
  apb_data_t                  prdata_o;
  logic                       pready_o;
  logic                       pslverr_o;
  logic                       noc2_valid_o;
  noc_flit_t                  noc2_data_o;
  logic                       noc2_ready_i;
  logic                       noc3_valid_i;
  noc_flit_t                  noc3_data_i;
  logic                       noc3_ready_o;

  integer    seed;
  apb_data_t rand_word;
  int        err_cnt;
  int        cycle_cnt;
  int        wake_len;
  noc_flit_t flits [0:7];
  int        num_flits;

  noc_tile_top UUT (.*);

  bind noc_tile_top noc_tile_props props_i (
    .clk_i        (clk_i),
    .reset_l      (reset_l),
    .spc_grst_l   (spc_grst_l),
    .irq_i        (irq_i),
    .ipi_i        (ipi_i),
    .time_irq_i   (time_irq_i),
    .debug_req_i  (debug_req_i),
    .irq_o        (irq_o),
    .ipi_o        (ipi_o),
    .time_irq_o   (time_irq_o),
    .debug_req_o  (debug_req_o),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .noc2_valid_o (noc2_valid_o),
    .noc2_data_o  (noc2_data_o),
    .noc2_ready_i (noc2_ready_i),
    .noc3_ready_o (noc3_ready_o)
  );

  //////////////////////////////////////////////////
  // clock, random lines and cycle limit
  //////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // all random draws in one process, so the sequence is fixed
  always @(posedge clk_i) begin
    logic [31:0] rnd_ctl;
    logic [31:0] rnd_hi;
    logic [31:0] rnd_lo;
    rnd_ctl = $random(seed);
    rnd_hi  = $random(seed);
    rnd_lo  = $random(seed);
    irq_i       <= rnd_ctl[1:0];
    ipi_i       <= rnd_ctl[2];
    time_irq_i  <= rnd_ctl[3];
    debug_req_i <= rnd_ctl[4];
    // ready about three cycles in four
    noc2_ready_i <= |rnd_ctl[6:5];
    rand_word    <= {rnd_hi, rnd_lo};
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("timeout after %0d cycles, a handshake never completed", cycle_cnt);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // checks and packet models
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // header layout, shared by both channels
  function automatic noc_flit_t header_flit(input chipid_t chip, input coord_t x,
                                            input coord_t y, input fbits_t fb,
                                            input msg_len_t len, input msg_type_e typ);
    noc_flit_t f;
    f        = '0;
    f[63:50] = chip;
    f[49:42] = x;
    f[41:34] = y;
    f[33:30] = fb;
    f[29:22] = len;
    f[21:14] = typ;
    return f;
  endfunction

  function automatic noc_flit_t source_flit(input apb_strb_t mask);
    noc_flit_t f;
    f        = '0;
    f[41:34] = mask;
    f[33:20] = src_chipid_i;
    f[19:12] = src_x_i;
    f[11:4]  = src_y_i;
    f[3:0]   = `TILE_FBITS_SRC;
    return f;
  endfunction

  // holds the flit until the unpacker takes it
  task automatic send_flit(input noc_flit_t flit);
    @(posedge clk_i);
    noc3_valid_i <= 1'b1;
    noc3_data_i  <= flit;
    do @(negedge clk_i); while (!noc3_ready_o);
  endtask

  task automatic run_transfer(input logic write, input logic nack);
    apb_addr_t addr;
    apb_data_t wdata;
    apb_data_t rdata;
    apb_strb_t strb;
    msg_len_t  len;
    msg_type_e typ;
    @(negedge clk_i);
    addr = rand_word[31:0];
    strb = rand_word[39:32];
    @(negedge clk_i);
    wdata = rand_word;
    len   = write ? msg_len_t'(3) : msg_len_t'(2);
    typ   = write ? MSG_STORE : MSG_LOAD;
    // setup phase then access phase
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= write;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    pstrb_i   <= strb;
    @(posedge clk_i);
    penable_i <= 1'b1;
    // collect flits until valid drops after the last one
    num_flits = 0;
    do begin
      @(negedge clk_i);
      if (noc2_valid_o && noc2_ready_i) begin
        if (num_flits < 8) begin
          flits[num_flits] = noc2_data_o;
        end
        num_flits++;
      end
    end while (num_flits == 0 || noc2_valid_o);
    check_value("noc2 flit count", 64'(num_flits), write ? 64'd4 : 64'd3);
    check_value("noc2_data_o header", flits[0], header_flit(`TILE_DEST_CHIPID,
                `TILE_DEST_X, `TILE_DEST_Y, `TILE_FBITS_MEM, len, typ));
    check_value("noc2_data_o source", flits[1], source_flit(write ? strb : 8'hff));
    check_value("noc2_data_o address", flits[2], {32'b0, addr});
    if (write) begin
      check_value("noc2_data_o data", flits[3], wdata);
    end
    // response on noc3
    @(negedge clk_i);
    rdata = rand_word;
    if (nack) begin
      send_flit(header_flit(src_chipid_i, src_x_i, src_y_i, `TILE_FBITS_SRC,
                            msg_len_t'(0), MSG_NACK));
    end else if (write) begin
      send_flit(header_flit(src_chipid_i, src_x_i, src_y_i, `TILE_FBITS_SRC,
                            msg_len_t'(0), MSG_STORE_ACK));
    end else begin
      send_flit(header_flit(src_chipid_i, src_x_i, src_y_i, `TILE_FBITS_SRC,
                            msg_len_t'(1), MSG_LOAD_ACK));
      send_flit(rdata);
    end
    @(posedge clk_i);
    noc3_valid_i <= 1'b0;
    do @(negedge clk_i); while (!pready_o);
    check_value("pslverr_o", 64'(pslverr_o), 64'(nack));
    if (!write && !nack) begin
      check_value("prdata_o", prdata_o, rdata);
    end
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    seed         = 32'hdb53;
    err_cnt      = 0;
    cycle_cnt    = 0;
    reset_l      = 1'b0;
    src_chipid_i = 14'h01a5;
    src_x_i      = 8'h03;
    src_y_i      = 8'h07;
    irq_i        = '0;
    ipi_i        = 1'b0;
    time_irq_i   = 1'b0;
    debug_req_i  = 1'b0;
    psel_i       = 1'b0;
    penable_i    = 1'b0;
    pwrite_i     = 1'b0;
    paddr_i      = '0;
    pwdata_i     = '0;
    pstrb_i      = '0;
    noc2_ready_i = 1'b0;
    noc3_valid_i = 1'b0;
    noc3_data_i  = '0;
    rand_word    = '0;
    repeat (reset_cycles) @(posedge clk_i);
    reset_l <= 1'b1;
    // count cycles to the tile reset release
    wake_len = 0;
    do begin
      @(posedge clk_i);
      wake_len++;
      @(negedge clk_i);
    end while (!spc_grst_l);
    check_value("spc_grst_l release cycle", 64'(wake_len), 64'(wake_cycles));
    repeat (4) begin
      @(negedge clk_i);
      check_value("noc2_valid_o", 64'(noc2_valid_o), 64'd0);
      check_value("pready_o", 64'(pready_o), 64'd0);
      check_value("pslverr_o", 64'(pslverr_o), 64'd0);
    end
    // store ack, load ack, store nack, load nack in turn
    for (int i = 0; i < num_xfers; i++) begin
      run_transfer(i % 2 == 0, i % 4 >= 2);
    end
    repeat (4) @(posedge clk_i);
    $display("checks done: %0d value errors, %0d property errors", err_cnt,
             UUT.props_i.fail_cnt);
    if (err_cnt == 0 && UUT.props_i.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/irq_sync.sv
`timescale 1ns/10ps
`include "tile_settings.svh"

module irq_sync (
  input  logic                       clk_i,
  input  logic                       reset_l,
  input  logic [`TILE_IRQ_WIDTH-1:0] irq_i,
  input  logic                       ipi_i,
  input  logic                       time_irq_i,
  input  logic                       debug_req_i,
  output logic [`TILE_IRQ_WIDTH-1:0] irq_o,
  output logic                       ipi_o,
  output logic                       time_irq_o,
  output logic                       debug_req_o
);

  // irq lines plus ipi, timer and debug
  localparam int num_lines = `TILE_IRQ_WIDTH + 3;

  logic [num_lines-1:0] async_in;
  logic [num_lines-1:0] meta_q;
  logic [num_lines-1:0] sync_q;

  // all sources are asynchronous to clk_i
  assign async_in = {irq_i, ipi_i, time_irq_i, debug_req_i};

  // two flops per line
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= async_in;
      sync_q <= meta_q;
    end
  end

  assign {irq_o, ipi_o, time_irq_o, debug_req_o} = sync_q;

endmodule

//--- verilog/noc_req_packer.sv
`timescale 1ns/10ps
`include "tile_settings.svh"

module noc_req_packer
  import tile_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_l,
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  apb_addr_t paddr_i,
  input  apb_data_t pwdata_i,
  input  apb_strb_t pstrb_i,
  input  chipid_t   src_chipid_i,
  input  coord_t    src_x_i,
  input  coord_t    src_y_i,
  input  logic      resp_done_i,
  output logic      noc2_valid_o,
  output noc_flit_t noc2_data_o,
  input  logic      noc2_ready_i
);

  pack_state_e state_q;
  pack_state_e state_d;

  // request held for the whole packet
  logic      req_write;
  apb_addr_t req_addr;
  apb_data_t req_data;
  apb_strb_t req_strb;

  logic      access_start;
  logic      flit_sent;
  msg_type_e req_type;
  msg_len_t  req_len;
  apb_strb_t flit_strb;

  // first cycle of the access phase
  assign access_start = psel_i & penable_i & (state_q == PACK_IDLE);
  assign flit_sent    = noc2_valid_o & noc2_ready_i;

  always_ff @(posedge clk_i) begin
    if (access_start) begin
      req_write <= pwrite_i;
      req_addr  <= paddr_i;
      req_data  <= pwdata_i;
      req_strb  <= pstrb_i;
    end
  end

  //////////////////////////////////////////////////
  // packet fsm
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      PACK_IDLE: begin
        if (access_start) begin
          state_d = PACK_HEADER;
        end
      end
      PACK_HEADER: begin
        if (flit_sent) begin
          state_d = PACK_SOURCE;
        end
      end
      PACK_SOURCE: begin
        if (flit_sent) begin
          state_d = PACK_ADDR;
        end
      end
      PACK_ADDR: begin
        // loads carry no data flit
        if (flit_sent) begin
          state_d = req_write ? PACK_DATA : PACK_WAIT;
        end
      end
      PACK_DATA: begin
        if (flit_sent) begin
          state_d = PACK_WAIT;
        end
      end
      PACK_WAIT: begin
        // hold off the next access until the response is back
        if (resp_done_i) begin
          state_d = PACK_IDLE;
        end
      end
      default: state_d = PACK_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      state_q <= PACK_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////
  // flit build
  //////////////////////////////////////////////////

  assign req_type  = req_write ? MSG_STORE : MSG_LOAD;
  assign req_len   = req_write ? msg_len_t'(3) : msg_len_t'(2);
  // full mask for loads
  assign flit_strb = req_write ? req_strb : '1;

  assign noc2_valid_o = state_q inside {PACK_HEADER, PACK_SOURCE, PACK_ADDR, PACK_DATA};

  // state and captured request only, so stable under backpressure
  always_comb begin
    case (state_q)
      PACK_HEADER: noc2_data_o = {`TILE_DEST_CHIPID, `TILE_DEST_X, `TILE_DEST_Y,
                                  `TILE_FBITS_MEM, req_len, req_type, 14'b0};
      PACK_SOURCE: noc2_data_o = {22'b0, flit_strb, src_chipid_i, src_x_i, src_y_i,
                                  `TILE_FBITS_SRC};
      PACK_ADDR:   noc2_data_o = {{(`TILE_NOC_WIDTH-`TILE_ADDR_WIDTH){1'b0}}, req_addr};
      PACK_DATA:   noc2_data_o = req_data;
      default:     noc2_data_o = '0;
    endcase
  end

endmodule

//--- verilog/noc_resp_unpacker.sv
`timescale 1ns/10ps
`include "tile_settings.svh"

module noc_resp_unpacker
  import tile_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_l,
  input  logic      noc3_valid_i,
  input  noc_flit_t noc3_data_i,
  output logic      noc3_ready_o,
  output apb_data_t prdata_o,
  output logic      pready_o,
  output logic      pslverr_o
);

  // header fields
  msg_len_t                    hdr_len;
  logic [`TILE_TYPE_WIDTH-1:0] hdr_type;
  logic                        hdr_ok;

  // packet progress
  logic     in_body_q;
  msg_len_t remain_q;
  logic     load_q;
  logic     err_q;

  logic flit_rcvd;
  logic last_flit;
  logic last_err;

  assign flit_rcvd = noc3_valid_i & noc3_ready_o;
  assign hdr_len   = noc3_data_i[29:22];
  assign hdr_type  = noc3_data_i[21:14];

  // nack and unknown types end in an apb error
  assign hdr_ok = (hdr_type == MSG_LOAD_ACK) || (hdr_type == MSG_STORE_ACK);

  // a zero length header ends the packet by itself
  assign last_flit = flit_rcvd &&
                     (in_body_q ? (remain_q == msg_len_t'(1)) : (hdr_len == '0));
  assign last_err  = in_body_q ? err_q : !hdr_ok;

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      in_body_q    <= 1'b0;
      remain_q     <= '0;
      load_q       <= 1'b0;
      err_q        <= 1'b0;
      noc3_ready_o <= 1'b0;
      pready_o     <= 1'b0;
      pslverr_o    <= 1'b0;
    end else begin
      // single cycle completion
      pready_o     <= last_flit;
      pslverr_o    <= last_flit & last_err;
      // closed during the completion cycle
      noc3_ready_o <= !last_flit;
      if (flit_rcvd) begin
        in_body_q <= !last_flit;
      end
      if (flit_rcvd && !in_body_q) begin
        remain_q <= hdr_len;
        load_q   <= (hdr_type == MSG_LOAD_ACK);
        err_q    <= !hdr_ok;
      end else if (flit_rcvd) begin
        remain_q <= remain_q - msg_len_t'(1);
      end
    end
  end

  // read data follows a load ack
  always_ff @(posedge clk_i) begin
    if (flit_rcvd && in_body_q && load_q) begin
      prdata_o <= noc3_data_i;
    end
  end

endmodule

//--- verilog/noc_tile_top.sv
`timescale 1ns/10ps
`include "tile_settings.svh"

module noc_tile_top
  import tile_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       reset_l,
  output logic                       spc_grst_l,
  // static network position
  input  chipid_t                    src_chipid_i,
  input  coord_t                     src_x_i,
  input  coord_t                     src_y_i,
  // async interrupt and debug lines
  input  logic [`TILE_IRQ_WIDTH-1:0] irq_i,
  input  logic                       ipi_i,
  input  logic                       time_irq_i,
  input  logic                       debug_req_i,
  output logic [`TILE_IRQ_WIDTH-1:0] irq_o,
  output logic                       ipi_o,
  output logic                       time_irq_o,
  output logic                       debug_req_o,
  // apb completer
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  apb_addr_t                  paddr_i,
  input  apb_data_t                  pwdata_i,
  input  apb_strb_t                  pstrb_i,
  output apb_data_t                  prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  // request network
  output logic                       noc2_valid_o,
  output noc_flit_t                  noc2_data_o,
  input  logic                       noc2_ready_i,
  // response network
  input  logic                       noc3_valid_i,
  input  noc_flit_t                  noc3_data_i,
  output logic                       noc3_ready_o
);

  // apb completion releases the packer
  logic resp_done;

  assign resp_done = pready_o;

  //////////////////////////////////////////////////
  // reset and interrupt conditioning
  //////////////////////////////////////////////////

  tile_reset_ctrl i_reset_ctrl (
    .clk_i      (clk_i),
    .reset_l    (reset_l),
    .spc_grst_l (spc_grst_l)
  );

  // everything below runs on the released tile reset
  irq_sync i_irq_sync (
    .clk_i       (clk_i),
    .reset_l     (spc_grst_l),
    .irq_i       (irq_i),
    .ipi_i       (ipi_i),
    .time_irq_i  (time_irq_i),
    .debug_req_i (debug_req_i),
    .irq_o       (irq_o),
    .ipi_o       (ipi_o),
    .time_irq_o  (time_irq_o),
    .debug_req_o (debug_req_o)
  );

  //////////////////////////////////////////////////
  // noc bridge
  //////////////////////////////////////////////////

  noc_req_packer i_req_packer (
    .clk_i        (clk_i),
    .reset_l      (spc_grst_l),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .pstrb_i      (pstrb_i),
    .src_chipid_i (src_chipid_i),
    .src_x_i      (src_x_i),
    .src_y_i      (src_y_i),
    .resp_done_i  (resp_done),
    .noc2_valid_o (noc2_valid_o),
    .noc2_data_o  (noc2_data_o),
    .noc2_ready_i (noc2_ready_i)
  );

  noc_resp_unpacker i_resp_unpacker (
    .clk_i        (clk_i),
    .reset_l      (spc_grst_l),
    .noc3_valid_i (noc3_valid_i),
    .noc3_data_i  (noc3_data_i),
    .noc3_ready_o (noc3_ready_o),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o)
  );

endmodule

//--- verilog/tile_pkg.sv
`include "tile_settings.svh"

package tile_pkg;

  //////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////

  // one network flit
  typedef logic [`TILE_NOC_WIDTH-1:0] noc_flit_t;

  // apb request fields
  typedef logic [`TILE_ADDR_WIDTH-1:0] apb_addr_t;
  typedef logic [`TILE_DATA_WIDTH-1:0] apb_data_t;
  // one bit per data byte
  typedef logic [`TILE_DATA_WIDTH/8-1:0] apb_strb_t;

  // network position of a tile
  typedef logic [`TILE_CHIPID_WIDTH-1:0] chipid_t;
  typedef logic [`TILE_XY_WIDTH-1:0] coord_t;
  typedef logic [`TILE_FBITS_WIDTH-1:0] fbits_t;

  // payload flits after the header
  typedef logic [`TILE_LEN_WIDTH-1:0] msg_len_t;

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////

  // header message type
  typedef enum logic [`TILE_TYPE_WIDTH-1:0] {
    MSG_LOAD      = 8'd19,
    MSG_STORE     = 8'd20,
    MSG_LOAD_ACK  = 8'd24,
    MSG_STORE_ACK = 8'd25,
    MSG_NACK      = 8'd33
  } msg_type_e;

  // request packer fsm
  typedef enum logic [2:0] {
    PACK_IDLE,
    PACK_HEADER,
    PACK_SOURCE,
    PACK_ADDR,
    PACK_DATA,
    PACK_WAIT
  } pack_state_e;

endpackage

//--- verilog/tile_reset_ctrl.sv
`timescale 1ns/10ps
`include "tile_settings.svh"

module tile_reset_ctrl (
  input  logic clk_i,
  input  logic reset_l,
  output logic spc_grst_l
);

  //////////////////////////////////////////////////
  // wake-up counter
  //////////////////////////////////////////////////

  logic [`TILE_WAKE_WIDTH-1:0] wake_cnt;
  logic                        wake_done;
  logic                        rst_pre_l;
  logic                        rst_meta;

  // network-side srams need time to initialise
  assign wake_done = wake_cnt[`TILE_WAKE_WIDTH-1];

  // saturates once the top bit is set
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      wake_cnt <= '0;
    end else if (!wake_done) begin
      wake_cnt <= wake_cnt + {{(`TILE_WAKE_WIDTH-1){1'b0}}, 1'b1};
    end
  end

  //////////////////////////////////////////////////
  // reset synchronizer
  //////////////////////////////////////////////////

  // gated with the raw reset
  assign rst_pre_l = wake_done & reset_l;

  // assert asynchronously, release after two flops
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      rst_meta   <= 1'b0;
      spc_grst_l <= 1'b0;
    end else begin
      rst_meta   <= rst_pre_l;
      spc_grst_l <= rst_meta;
    end
  end

endmodule

//--- verilog/tile_settings.svh
`ifndef TILE_SETTINGS_SVH
`define TILE_SETTINGS_SVH

//////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////

// one flit per cycle on noc2 and noc3
`define TILE_NOC_WIDTH 64

// apb completer side
`define TILE_ADDR_WIDTH 32
`define TILE_DATA_WIDTH 64

// network id fields
`define TILE_CHIPID_WIDTH 14
`define TILE_XY_WIDTH 8
`define TILE_FBITS_WIDTH 4

// header length and message type fields
`define TILE_LEN_WIDTH 8
`define TILE_TYPE_WIDTH 8

// release waits for the top bit of this counter
`define TILE_WAKE_WIDTH 6

// level sensitive interrupt lines
`define TILE_IRQ_WIDTH 2

//////////////////////////////////////////////////
// fixed packet routing
//////////////////////////////////////////////////

// memory controller chip, only top bit set
`define TILE_DEST_CHIPID 14'h2000
`define TILE_DEST_X 8'd0
`define TILE_DEST_Y 8'd0
`define TILE_FBITS_MEM 4'h2

// responses come back to these final bits
`define TILE_FBITS_SRC 4'h5

`endif
